// File: compile.f
hw/rv_pkg.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/mem_access.sv
hw/rv_pipeline.sv
tb/rv_pipeline_checker.sv
tb/tb_rv_pipeline.sv

// File: hw/decode_unit.sv
module decode_unit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            advance,
    input  rv_pkg::instr_t                  id_instr,
    input  logic [rv_pkg::REG_ADDR_W-1:0]   wb_rd,
    input  logic                            wb_reg_write,
    input  logic [rv_pkg::XLEN-1:0]         wb_data,
    output logic [rv_pkg::REG_ADDR_W-1:0]   ex_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0]   ex_rs2,
    output logic [rv_pkg::REG_ADDR_W-1:0]   ex_rd,
    output logic [rv_pkg::XLEN-1:0]         ex_a,
    output logic [rv_pkg::XLEN-1:0]         ex_b,
    output logic [rv_pkg::XLEN-1:0]         ex_imm,
    output logic                            ex_use_imm,
    output logic                            ex_is_lui,
    output logic                            ex_reg_write,
    output logic                            ex_mem_read,
    output logic                            ex_mem_write,
    output logic [rv_pkg::ALU_OP_W-1:0]     ex_alu_op,
    output logic [2:0]                      ex_funct3
);

    logic [rv_pkg::XLEN-1:0]     rs1_data, rs2_data, imm;
    logic [rv_pkg::ALU_OP_W-1:0] alu_op;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    logic                        is_reg, f7_ok, arith_ok;
    logic                        use_imm, is_lui, reg_write, mem_read, mem_write;

    reg_file i_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (id_instr.r.rs1),
        .rs2_addr (id_instr.r.rs2),
        .wr_addr  (wb_rd),
        .wr_en    (wb_reg_write),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign funct3 = id_instr.r.funct3;
    assign funct7 = id_instr.r.funct7;
    assign is_reg = (id_instr.r.opcode == rv_pkg::OP_REG);

    // funct7 only matters for register ops and immediate shifts
    assign f7_ok = !(is_reg || funct3 == 3'b001 || funct3 == 3'b101)
                   || funct7 == 7'b0000000
                   || (funct7 == 7'b0100000 && (funct3 == 3'b101 || (is_reg && funct3 == 3'b000)));

    always_comb
    begin
        arith_ok = f7_ok;
        alu_op   = rv_pkg::ALU_ADD;
        case (funct3)
            3'b000:  alu_op = (is_reg && funct7[5]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  alu_op = rv_pkg::ALU_SLL;
            3'b100:  alu_op = rv_pkg::ALU_XOR;
            3'b101:  alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_op = rv_pkg::ALU_OR;
            3'b111:  alu_op = rv_pkg::ALU_AND;
            default: arith_ok = 1'b0; // slt forms become no-ops
        endcase
        if (!is_reg && id_instr.r.opcode != rv_pkg::OP_IMM)
        begin
            alu_op = rv_pkg::ALU_ADD; // loads and stores only add the offset
        end
    end

    always_comb
    begin
        imm       = '0;
        use_imm   = 1'b0;
        is_lui    = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        case (id_instr.r.opcode)
            rv_pkg::OP_IMM:
            begin
                imm       = {{20{id_instr.i.imm[11]}}, id_instr.i.imm};
                use_imm   = 1'b1;
                reg_write = arith_ok;
            end
            rv_pkg::OP_REG:
                reg_write = arith_ok;
            rv_pkg::OP_LUI:
            begin
                imm       = {id_instr.u.imm, 12'h000};
                is_lui    = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::OP_LOAD:
            begin
                imm       = {{20{id_instr.i.imm[11]}}, id_instr.i.imm};
                use_imm   = 1'b1;
                mem_read  = funct3 inside {rv_pkg::F3_B, rv_pkg::F3_H, rv_pkg::F3_W,
                                           rv_pkg::F3_BU, rv_pkg::F3_HU};
                reg_write = mem_read;
            end
            rv_pkg::OP_STORE:
            begin
                imm       = {{20{id_instr.s.imm_hi[6]}}, id_instr.s.imm_hi, id_instr.s.imm_lo};
                use_imm   = 1'b1;
                mem_write = funct3 inside {rv_pkg::F3_B, rv_pkg::F3_H, rv_pkg::F3_W};
            end
            default: ; // anything else is a bubble
        endcase
    end

    // ID/EX control
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end
        else if (advance)
        begin
            ex_reg_write <= reg_write;
            ex_mem_read  <= mem_read;
            ex_mem_write <= mem_write;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            ex_rs1     <= id_instr.r.rs1;
            ex_rs2     <= id_instr.r.rs2;
            ex_rd      <= id_instr.r.rd;
            ex_a       <= rs1_data;
            ex_b       <= rs2_data;
            ex_imm     <= imm;
            ex_use_imm <= use_imm;
            ex_is_lui  <= is_lui;
            ex_alu_op  <= alu_op;
            ex_funct3  <= funct3;
        end
    end

endmodule

// File: hw/execute_unit.sv
module execute_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          advance,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs2,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic [rv_pkg::XLEN-1:0]       ex_a,
    input  logic [rv_pkg::XLEN-1:0]       ex_b,
    input  logic [rv_pkg::XLEN-1:0]       ex_imm,
    input  logic                          ex_use_imm,
    input  logic                          ex_is_lui,
    input  logic                          ex_reg_write,
    input  logic                          ex_mem_read,
    input  logic                          ex_mem_write,
    input  logic [rv_pkg::ALU_OP_W-1:0]   ex_alu_op,
    input  logic [2:0]                    ex_funct3,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic                          wb_reg_write,
    input  logic [rv_pkg::XLEN-1:0]       mem_result,
    input  logic [rv_pkg::XLEN-1:0]       wb_data,
    output logic [rv_pkg::REG_ADDR_W-1:0] mem_rd,
    output logic                          mem_reg_write,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic [rv_pkg::XLEN-1:0]       mem_alu,
    output logic [rv_pkg::XLEN-1:0]       mem_store_data,
    output logic [2:0]                    mem_funct3
);

    logic [rv_pkg::XLEN-1:0] op_a, op_b, src_b, alu_out, result;

    // newest producer wins, MEM before WB
    function automatic logic [rv_pkg::XLEN-1:0] fwd(input logic [4:0] idx,
                                                   input logic [rv_pkg::XLEN-1:0] id_val);
        if (idx != '0 && mem_reg_write && idx == mem_rd)
            return mem_result;
        if (idx != '0 && wb_reg_write && idx == wb_rd)
            return wb_data;
        return id_val;
    endfunction

    always_comb
    begin
        op_a  = fwd(ex_rs1, ex_a);
        op_b  = fwd(ex_rs2, ex_b); // also the store data
        src_b = ex_use_imm ? ex_imm : op_b;
        case (ex_alu_op)
            rv_pkg::ALU_ADD: alu_out = op_a + src_b;
            rv_pkg::ALU_SUB: alu_out = op_a - src_b;
            rv_pkg::ALU_SLL: alu_out = op_a << src_b[4:0];
            rv_pkg::ALU_SRL: alu_out = op_a >> src_b[4:0];
            rv_pkg::ALU_SRA: alu_out = $signed(op_a) >>> src_b[4:0];
            rv_pkg::ALU_AND: alu_out = op_a & src_b;
            rv_pkg::ALU_OR:  alu_out = op_a | src_b;
            default:         alu_out = op_a ^ src_b;
        endcase
        result = ex_is_lui ? ex_imm : alu_out;
    end

    // EX/MEM control
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_reg_write <= 1'b0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
        end
        else if (advance)
        begin
            mem_reg_write <= ex_reg_write;
            mem_read      <= ex_mem_read;
            mem_write     <= ex_mem_write;
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            mem_rd         <= ex_rd;
            mem_alu        <= result;
            mem_store_data <= op_b;
            mem_funct3     <= ex_funct3;
        end
    end

endmodule

// File: hw/fetch_unit.sv
module fetch_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    advance,
    input  rv_pkg::instr_t          inst_rdata,
    output logic                    inst_read,
    output logic [rv_pkg::XLEN-1:0] inst_addr,
    output rv_pkg::instr_t          id_instr
);

    // fetch runs every cycle once out of reset
    assign inst_read = ~reset;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            inst_addr <= rv_pkg::RESET_PC;
        end
        else if (advance)
        begin
            inst_addr <= inst_addr + 32'd4; // no redirects, strictly sequential
        end
    end

    // IF/ID instruction register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            id_instr <= rv_pkg::NOP_INSTR;
        end
        else if (advance)
        begin
            id_instr <= inst_rdata;
        end
    end

endmodule

// File: hw/mem_access.sv
module mem_access (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          inst_resp,
    input  logic                          data_resp,
    input  logic [rv_pkg::XLEN-1:0]       data_rdata,
    input  logic [rv_pkg::REG_ADDR_W-1:0] mem_rd,
    input  logic                          mem_reg_write,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  logic [rv_pkg::XLEN-1:0]       mem_alu,
    input  logic [rv_pkg::XLEN-1:0]       mem_store_data,
    input  logic [2:0]                    mem_funct3,
    output logic                          advance,
    output logic                          data_read,
    output logic                          data_write,
    output logic [rv_pkg::XLEN-1:0]       data_addr,
    output logic [rv_pkg::XLEN-1:0]       data_wdata,
    output logic [3:0]                    data_mbe,
    output logic [rv_pkg::XLEN-1:0]       mem_result,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic                          wb_reg_write,
    output logic [rv_pkg::XLEN-1:0]       wb_data
);

    logic [1:0]              offset;
    logic [rv_pkg::XLEN-1:0] byte_word, load_val;
    logic [15:0]             half;

    // whole pipe holds until both ports are satisfied
    assign advance = inst_resp & (data_resp | ~(data_read | data_write));

    assign data_read  = mem_read;
    assign data_write = mem_write;
    assign data_addr  = {mem_alu[rv_pkg::XLEN-1:2], 2'b00};
    assign offset     = mem_alu[1:0];

    // store lane placement
    always_comb
    begin
        data_mbe   = 4'b0000;
        data_wdata = mem_store_data;
        if (mem_write)
        begin
            case (mem_funct3)
                rv_pkg::F3_B:
                begin
                    data_mbe   = 4'b0001 << offset;
                    data_wdata = {24'b0, mem_store_data[7:0]} << {offset, 3'b000};
                end
                rv_pkg::F3_H:
                begin
                    data_mbe   = offset[1] ? 4'b1100 : 4'b0011;
                    data_wdata = {16'b0, mem_store_data[15:0]} << {offset[1], 4'b0000};
                end
                default:
                    data_mbe = 4'b1111; // sw
            endcase
        end
    end

    // load lane extraction
    assign byte_word = data_rdata >> {offset, 3'b000};
    assign half      = offset[1] ? data_rdata[31:16] : data_rdata[15:0];

    always_comb
    begin
        case (mem_funct3)
            rv_pkg::F3_B:  load_val = {{24{byte_word[7]}}, byte_word[7:0]};
            rv_pkg::F3_BU: load_val = {24'b0, byte_word[7:0]};
            rv_pkg::F3_H:  load_val = {{16{half[15]}}, half};
            rv_pkg::F3_HU: load_val = {16'b0, half};
            default:       load_val = data_rdata;
        endcase
    end

    assign mem_result = mem_read ? load_val : mem_alu; // also feeds EX forwarding

    // MEM/WB
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_reg_write <= 1'b0;
        end
        else if (advance)
        begin
            wb_reg_write <= mem_reg_write;
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            wb_rd   <= mem_rd;
            wb_data <= mem_result;
        end
    end

endmodule

// File: hw/reg_file.sv
module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic                          wr_en,
    input  logic [rv_pkg::XLEN-1:0]       wr_data,
    output logic [rv_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_pkg::XLEN-1:0]       rs2_data
);

    logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && wr_addr != '0)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through so decode sees the value landing this edge
    function automatic logic [rv_pkg::XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == '0)
            return '0;
        if (wr_en && wr_addr == addr)
            return wr_data;
        return regs[addr];
    endfunction

    always_comb
    begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

// File: hw/rv_pipeline.sv
module rv_pipeline (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inst_resp,
    input  logic                    data_resp,
    input  logic [rv_pkg::XLEN-1:0] inst_rdata,
    input  logic [rv_pkg::XLEN-1:0] data_rdata,
    output logic                    inst_read,
    output logic                    data_read,
    output logic                    data_write,
    output logic [rv_pkg::XLEN-1:0] inst_addr,
    output logic [rv_pkg::XLEN-1:0] data_addr,
    output logic [rv_pkg::XLEN-1:0] data_wdata,
    output logic [3:0]              data_mbe
);

    logic                          advance;
    rv_pkg::instr_t                id_instr;

    // ID/EX
    logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;
    logic [rv_pkg::XLEN-1:0]       ex_a, ex_b, ex_imm;
    logic                          ex_use_imm, ex_is_lui, ex_reg_write;
    logic                          ex_mem_read, ex_mem_write;
    logic [rv_pkg::ALU_OP_W-1:0]   ex_alu_op;
    logic [2:0]                    ex_funct3;

    // EX/MEM
    logic [rv_pkg::REG_ADDR_W-1:0] mem_rd;
    logic                          mem_reg_write, mem_read, mem_write;
    logic [rv_pkg::XLEN-1:0]       mem_alu, mem_store_data, mem_result;
    logic [2:0]                    mem_funct3;

    // MEM/WB
    logic [rv_pkg::REG_ADDR_W-1:0] wb_rd;
    logic                          wb_reg_write;
    logic [rv_pkg::XLEN-1:0]       wb_data;

    fetch_unit i_fetch_unit (
        .clk(clk), .reset(reset), .advance(advance),
        .inst_rdata(inst_rdata), .inst_read(inst_read), .inst_addr(inst_addr),
        .id_instr(id_instr)
    );

    decode_unit i_decode_unit (
        .clk(clk), .reset(reset), .advance(advance), .id_instr(id_instr),
        .wb_rd(wb_rd), .wb_reg_write(wb_reg_write), .wb_data(wb_data),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
        .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
        .ex_use_imm(ex_use_imm), .ex_is_lui(ex_is_lui), .ex_reg_write(ex_reg_write),
        .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
        .ex_alu_op(ex_alu_op), .ex_funct3(ex_funct3)
    );

    execute_unit i_execute_unit (
        .clk(clk), .reset(reset), .advance(advance),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
        .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
        .ex_use_imm(ex_use_imm), .ex_is_lui(ex_is_lui), .ex_reg_write(ex_reg_write),
        .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
        .ex_alu_op(ex_alu_op), .ex_funct3(ex_funct3),
        .wb_rd(wb_rd), .wb_reg_write(wb_reg_write),
        .mem_result(mem_result), .wb_data(wb_data),
        .mem_rd(mem_rd), .mem_reg_write(mem_reg_write),
        .mem_read(mem_read), .mem_write(mem_write),
        .mem_alu(mem_alu), .mem_store_data(mem_store_data), .mem_funct3(mem_funct3)
    );

    mem_access i_mem_access (
        .clk(clk), .reset(reset),
        .inst_resp(inst_resp), .data_resp(data_resp), .data_rdata(data_rdata),
        .mem_rd(mem_rd), .mem_reg_write(mem_reg_write),
        .mem_read(mem_read), .mem_write(mem_write),
        .mem_alu(mem_alu), .mem_store_data(mem_store_data), .mem_funct3(mem_funct3),
        .advance(advance), .data_read(data_read), .data_write(data_write),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_mbe(data_mbe),
        .mem_result(mem_result),
        .wb_rd(wb_rd), .wb_reg_write(wb_reg_write), .wb_data(wb_data)
    );

endmodule

// File: hw/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    // kept opcodes
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // load and store size / sign
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    localparam int ALU_OP_W = 3;
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SRL = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SRA = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd5;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd6;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd7;

    // one instruction word, four field layouts
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [6:0]            imm_hi;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
        struct packed {
            logic [19:0]           imm;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } u;
    } instr_t;

endpackage

// File: tb/rv_pipeline_checker.sv
module rv_pipeline_checker (
    input logic        clk,
    input logic        reset,
    input logic        inst_resp,
    input logic        data_resp,
    input logic        inst_read,
    input logic        data_read,
    input logic        data_write,
    input logic [31:0] inst_addr,
    input logic [31:0] data_addr,
    input logic [31:0] data_wdata,
    input logic [3:0]  data_mbe
);
    timeunit 1ns;
    timeprecision 100ps;

    int          error_count = 0;
    int          store_idx;
    logic [31:0] prev_addr;
    logic        adv, store_done;

    // expected stores: address, byte enables, lane data
    logic [31:0] exp_addr [23] = '{
        32'h100, 32'h104, 32'h108, 32'h10C, 32'h110, 32'h114, 32'h118, 32'h11C, 32'h120,
        32'h130, 32'h130, 32'h130, 32'h130, 32'h134, 32'h134,
        32'h140, 32'h144, 32'h148, 32'h14C, 32'h150, 32'h154, 32'h158, 32'h15C};
    logic [3:0]  exp_mbe [23] = '{
        4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,
        4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC,
        4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF};
    logic [31:0] exp_data [23] = '{
        32'h00000123, 32'hABCDE123, 32'hABCDE000, 32'h54321FFF, 32'h000000F0,
        32'hBCDE1230, 32'h00BCDE12, 32'hFFFABCDE, 32'hABC8A321,
        32'h00000023, 32'h00002300, 32'h00230000, 32'h23000000, 32'h0000E123, 32'hE1230000,
        32'hFFFFFFE2, 32'h000000E2, 32'h0000007F, 32'hFFFF80F1, 32'h000080F1,
        32'h00007FE2, 32'h80F17FE2, 32'h00000080};

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    assign adv        = inst_resp && (data_resp || !(data_read || data_write));
    assign store_done = data_write && data_resp && inst_resp;

    always_ff @(posedge clk)
    begin
        prev_addr <= inst_addr;
        if (reset)
            store_idx <= 0;
        else if (store_done)
            store_idx <= store_idx + 1; // one entry per completed store
    end

    a_reset_fetch: assert property (@(posedge clk) reset |-> !inst_read)
        else begin error_count++; $error("inst_read was high while reset was asserted"); end
    a_reset_pc: assert property (@(posedge clk) $fell(reset) |-> inst_addr == rv_pkg::RESET_PC)
        else begin error_count++; $error("mismatch inst_addr: got %h expected %h",
                                         $sampled(inst_addr), rv_pkg::RESET_PC); end
    a_reset_port: assert property (@(posedge clk)
        $fell(reset) |-> !data_read && !data_write && data_mbe == 4'h0)
        else begin error_count++; $error("data port was active on the first cycle after reset"); end

    // pc steps only on an advancing cycle
    a_fetch_step: assert property (@(posedge clk) disable iff (reset)
        adv |=> inst_addr == prev_addr + 32'd4)
        else begin error_count++; $error("mismatch inst_addr: got %h expected %h",
                                         $sampled(inst_addr), $sampled(prev_addr) + 32'd4); end
    a_fetch_hold: assert property (@(posedge clk) disable iff (reset) !adv |=> $stable(inst_addr))
        else begin error_count++; $error("inst_addr moved during a stalled cycle"); end
    a_stall_stable: assert property (@(posedge clk) disable iff (reset)
        (data_read || data_write) && !data_resp
        |=> $stable(data_addr) && $stable(data_wdata) && $stable(data_mbe))
        else begin error_count++; $error("data port outputs changed while an access waited"); end

    a_store_count: assert property (@(posedge clk) disable iff (reset)
        store_done |-> store_idx < $size(exp_addr))
        else begin error_count++; $error("more stores completed than the program holds"); end
    a_store_addr: assert property (@(posedge clk) disable iff (reset)
        store_done && store_idx < $size(exp_addr) |-> data_addr == exp_addr[store_idx])
        else begin error_count++; $error("mismatch data_addr: got %h expected %h",
                                         $sampled(data_addr), exp_addr[$sampled(store_idx)]); end
    a_store_mbe: assert property (@(posedge clk) disable iff (reset)
        store_done && store_idx < $size(exp_addr) |-> data_mbe == exp_mbe[store_idx])
        else begin error_count++; $error("mismatch data_mbe: got %h expected %h",
                                         $sampled(data_mbe), exp_mbe[$sampled(store_idx)]); end
    a_store_data: assert property (@(posedge clk) disable iff (reset)
        store_done && store_idx < $size(exp_addr)
        |-> (data_wdata & lane_mask(exp_mbe[store_idx])) == exp_data[store_idx])
        else begin error_count++; $error("mismatch data_wdata: got %h expected %h",
                                         $sampled(data_wdata), exp_data[$sampled(store_idx)]); end

endmodule

bind rv_pipeline rv_pipeline_checker i_checker (.*);

// File: tb/tb_rv_pipeline.sv
module tb_rv_pipeline;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk = 1'b0;
    logic        reset, inst_resp, data_resp;
    logic [31:0] inst_rdata, data_rdata, inst_addr, data_addr, data_wdata;
    logic        inst_read, data_read, data_write;
    logic [3:0]  data_mbe;

    rv_pkg::instr_t prog [64];
    logic [7:0]     dmem [512];
    integer         seed = 32'hf964;
    int             prog_len = 0;
    int             cycle_limit, cycles = 0, store_count = 0;
    int             tests_run = 0, errors;
    bit             timed_out = 0;
    int             section_end [3] = '{9, 15, 23};
    string          section_name [3] = '{"alu_forwarding", "store_lanes", "load_extraction"};

    rv_pipeline i_rv_pipeline (.*);

    function automatic rv_pkg::instr_t itype(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
                                             logic [4:0] rs1, logic [11:0] imm);
        rv_pkg::instr_t w;
        w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op};
        return w;
    endfunction

    function automatic rv_pkg::instr_t rtype(logic [6:0] f7, logic [4:0] rd, logic [2:0] f3,
                                             logic [4:0] rs1, logic [4:0] rs2);
        rv_pkg::instr_t w;
        w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: rv_pkg::OP_REG};
        return w;
    endfunction

    // store with base x0 and the immediate split across both fields
    function automatic rv_pkg::instr_t stype(logic [2:0] f3, logic [4:0] rs2, logic [11:0] imm);
        rv_pkg::instr_t w;
        w.s = '{imm_hi: imm[11:5], rs2: rs2, rs1: 5'd0, funct3: f3, imm_lo: imm[4:0],
                opcode: rv_pkg::OP_STORE};
        return w;
    endfunction

    function automatic rv_pkg::instr_t utype(logic [4:0] rd, logic [19:0] imm);
        rv_pkg::instr_t w;
        w.u = '{imm: imm, rd: rd, opcode: rv_pkg::OP_LUI};
        return w;
    endfunction

    task automatic emit(input rv_pkg::instr_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic load(input logic [2:0] f3, input logic [4:0] rd, input logic [11:0] addr);
        emit(itype(rv_pkg::OP_LOAD, rd, f3, 5'd0, addr));
    endtask

    task automatic build_program();
        emit(itype(rv_pkg::OP_IMM, 1, 3'b000, 0, 12'h123));    // addi x1
        emit(stype(rv_pkg::F3_W, 1, 12'h100));
        emit(utype(2, 20'hABCDE));
        emit(rtype(7'h00, 3, 3'b000, 2, 1));                   // add x3,x2,x1
        emit(stype(rv_pkg::F3_W, 3, 12'h104));
        emit(rtype(7'h20, 4, 3'b000, 3, 1));                   // sub
        emit(stype(rv_pkg::F3_W, 4, 12'h108));
        emit(itype(rv_pkg::OP_IMM, 5, 3'b100, 3, 12'hFFF));    // xori -1
        emit(rtype(7'h00, 6, 3'b110, 5, 1));                   // or
        emit(stype(rv_pkg::F3_W, 6, 12'h10C));
        emit(itype(rv_pkg::OP_IMM, 7, 3'b111, 6, 12'h0F0));    // andi
        emit(stype(rv_pkg::F3_W, 7, 12'h110));
        emit(itype(rv_pkg::OP_IMM, 8, 3'b001, 3, 12'h004));    // slli
        emit(stype(rv_pkg::F3_W, 8, 12'h114));
        emit(itype(rv_pkg::OP_IMM, 9, 3'b101, 8, 12'h008));    // srli
        emit(stype(rv_pkg::F3_W, 9, 12'h118));
        emit(itype(rv_pkg::OP_IMM, 10, 3'b101, 3, 12'h40C));   // srai
        emit(stype(rv_pkg::F3_W, 10, 12'h11C));
        emit(rtype(7'h00, 11, 3'b100, 10, 6));                 // xor with x10 from WB
        emit(stype(rv_pkg::F3_W, 11, 12'h120));
        for (int off = 0; off < 4; off++)
            emit(stype(rv_pkg::F3_B, 3, 12'h130 + off));
        emit(stype(rv_pkg::F3_H, 3, 12'h134));
        emit(stype(rv_pkg::F3_H, 3, 12'h136));
        load(rv_pkg::F3_B, 12, 12'h040);
        emit(stype(rv_pkg::F3_W, 12, 12'h140));
        load(rv_pkg::F3_BU, 13, 12'h040);
        emit(stype(rv_pkg::F3_W, 13, 12'h144));
        load(rv_pkg::F3_B, 14, 12'h041);
        emit(stype(rv_pkg::F3_W, 14, 12'h148));
        load(rv_pkg::F3_H, 15, 12'h042);
        emit(stype(rv_pkg::F3_W, 15, 12'h14C));
        load(rv_pkg::F3_HU, 16, 12'h042);
        emit(stype(rv_pkg::F3_W, 16, 12'h150));
        load(rv_pkg::F3_H, 17, 12'h040);
        emit(stype(rv_pkg::F3_W, 17, 12'h154));
        load(rv_pkg::F3_W, 18, 12'h040);
        emit(stype(rv_pkg::F3_W, 18, 12'h158));
        load(rv_pkg::F3_BU, 19, 12'h043);
        emit(stype(rv_pkg::F3_W, 19, 12'h15C));
    endtask

    initial
    begin
        forever #10 clk = ~clk;
    end

    // memory models drop about one response in four
    always @(negedge clk)
    begin
        inst_resp  = ($random(seed) & 3) != 0;
        data_resp  = ($random(seed) & 3) != 0;
        inst_rdata = (inst_addr[31:2] < 64) ? prog[inst_addr[7:2]] : rv_pkg::NOP_INSTR;
        if (data_read)
            data_rdata = {dmem[{data_addr[8:2], 2'd3}], dmem[{data_addr[8:2], 2'd2}],
                          dmem[{data_addr[8:2], 2'd1}], dmem[{data_addr[8:2], 2'd0}]};
        else
            data_rdata = '0; // read data only for a requested load
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= cycle_limit)
            timed_out = 1'b1;
        if (!reset && data_write && data_resp && inst_resp)
        begin
            store_count++;
            for (int b = 0; b < 4; b++)
                if (data_mbe[b])
                    dmem[{data_addr[8:2], 2'(b)}] = data_wdata[8*b +: 8];
        end
    end

    initial
    begin
        reset = 1'b1;
        inst_resp = 1'b0;
        data_resp = 1'b0;
        inst_rdata = rv_pkg::NOP_INSTR;
        data_rdata = '0;
        for (int a = 0; a < 64; a++)
            prog[a] = rv_pkg::NOP_INSTR;
        for (int a = 0; a < 512; a++)
            dmem[a] = 8'(a) ^ {a[8], 7'b0};  // fill depends on all address bits
        {dmem[8'h43], dmem[8'h42], dmem[8'h41], dmem[8'h40]} = 32'h80F17FE2;
        {dmem[8'h47], dmem[8'h46], dmem[8'h45], dmem[8'h44]} = 32'h1234ABCD;
        build_program();
        cycle_limit = 16 + 4 * prog_len + 50;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < 3; t++)
        begin
            while (store_count < section_end[t] && !timed_out)
                @(negedge clk);
            if (timed_out)
                break;
            tests_run++;
            $display("test %0d %s finished: %0d stores, %0d errors so far", t,
                     section_name[t], store_count, i_rv_pipeline.i_checker.error_count);
        end
        if (timed_out)
            $display("timeout: cycle limit %0d reached after %0d of %0d stores",
                     cycle_limit, store_count, section_end[2]);
        errors = i_rv_pipeline.i_checker.error_count;
        $display("tests run %0d of 3, errors %0d", tests_run, errors);
        if (timed_out || errors != 0)
            $display("Testbench failed");
        else
            $display("Testbench passed");
        $finish;
    end

endmodule
